// ==== source/radio_fe_pkg.sv ====
`default_nettype none

package radio_fe_pkg;

   localparam int SAMP_W      = 16;
   localparam int AXIL_ADDR_W = 12;
   localparam int AXIL_DATA_W = 32;

   ////////////////////////////////////////////////////////////////////////////
   // register map, word indices
   ////////////////////////////////////////////////////////////////////////////
   localparam int SR_TX_FE_BASE = 224;
   localparam int SR_RX_FE_BASE = 232;
   localparam int SR_STATUS     = 240;
   localparam int SR_OFF_I      = 0;
   localparam int SR_OFF_Q      = 1;
   localparam int SR_IQ_MAP     = 2;
   localparam int CHAN_SHIFT    = 8;   // channel c sits at index + c*256

   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

   // I in the upper half
   typedef struct packed {
      logic signed [SAMP_W-1:0] i;
      logic signed [SAMP_W-1:0] q;
   } iq_t;

   typedef struct packed {
      logic [SAMP_W-1:0] offset_i;
      logic [SAMP_W-1:0] offset_q;
      logic              iq_swap;
   } fe_rx_cfg_t;

   typedef struct packed {
      logic [SAMP_W-1:0] offset_i;
      logic [SAMP_W-1:0] offset_q;
      logic              iq_swap;
   } fe_tx_cfg_t;

   typedef struct packed {
      logic                   awvalid;
      logic [AXIL_ADDR_W-1:0] awaddr;
      logic                   wvalid;
      logic [AXIL_DATA_W-1:0] wdata;
      logic                   bready;
      logic                   arvalid;
      logic [AXIL_ADDR_W-1:0] araddr;
      logic                   rready;
   } axil_req_t;

   typedef struct packed {
      logic                   awready;
      logic                   wready;
      logic                   bvalid;
      logic [1:0]             bresp;
      logic                   arready;
      logic                   rvalid;
      logic [AXIL_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
   } axil_rsp_t;

   // top two bits of a guarded sum differ on overflow
   function automatic logic sample_clipped(input logic [SAMP_W:0] sum);
      return sum[SAMP_W] ^ sum[SAMP_W-1];
   endfunction

   function automatic logic [SAMP_W-1:0] clip_sample(input logic [SAMP_W:0] sum);
      logic [SAMP_W-1:0] res;
      if (!sample_clipped(sum)) begin
         res = sum[SAMP_W-1:0];
      end else if (sum[SAMP_W]) begin
         res = {1'b1, {(SAMP_W-1){1'b0}}};   // most negative
      end else begin
         res = {1'b0, {(SAMP_W-1){1'b1}}};   // most positive
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// ==== source/fe_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_axil_regs
   import radio_fe_pkg::*;
#(
   parameter int NUM_CHAN = 2
) (
   input  wire                         radio_clk,
   input  wire                         i_arst_n,
   input  wire axil_req_t              i_axil_req,
   output axil_rsp_t                   o_axil_rsp,
   output fe_rx_cfg_t [NUM_CHAN-1:0]   o_rx_cfg,
   output fe_tx_cfg_t [NUM_CHAN-1:0]   o_tx_cfg,
   input  wire [2*NUM_CHAN-1:0]        i_status,
   output logic [2*NUM_CHAN-1:0]       o_status_clr
);

   localparam int IDX_W = AXIL_ADDR_W - 2;     // word index width
   localparam int CH_W  = IDX_W - CHAN_SHIFT;

   logic [IDX_W-1:0]       wr_idx;
   logic [IDX_W-1:0]       rd_idx;
   logic [CH_W-1:0]        wr_chan;
   logic [CH_W-1:0]        rd_chan;
   logic [CHAN_SHIFT-1:0]  wr_reg;
   logic [CHAN_SHIFT-1:0]  rd_reg;
   logic                   wr_chan_ok;
   logic                   rd_chan_ok;
   logic                   wr_fire;
   logic                   rd_fire;
   logic                   bvalid;
   logic                   rvalid;
   logic [AXIL_DATA_W-1:0] rd_word;
   logic [AXIL_DATA_W-1:0] rdata;

   ////////////////////////////////////////////////////////////////////////////
   // address decode
   ////////////////////////////////////////////////////////////////////////////
   assign wr_idx     = i_axil_req.awaddr[AXIL_ADDR_W-1:2];
   assign rd_idx     = i_axil_req.araddr[AXIL_ADDR_W-1:2];
   assign wr_chan    = wr_idx[IDX_W-1:CHAN_SHIFT];
   assign rd_chan    = rd_idx[IDX_W-1:CHAN_SHIFT];
   assign wr_reg     = wr_idx[CHAN_SHIFT-1:0];
   assign rd_reg     = rd_idx[CHAN_SHIFT-1:0];
   assign wr_chan_ok = int'(wr_chan) < NUM_CHAN;
   assign rd_chan_ok = int'(rd_chan) < NUM_CHAN;

   // address and data are taken together, one write in flight
   assign wr_fire = i_axil_req.awvalid & i_axil_req.wvalid & ~bvalid;
   assign rd_fire = i_axil_req.arvalid & ~rvalid;

   assign o_status_clr = (wr_fire && wr_idx == IDX_W'(SR_STATUS)) ?
                         i_axil_req.wdata[2*NUM_CHAN-1:0] : '0;

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         bvalid   <= 1'b0;
         rvalid   <= 1'b0;
         o_rx_cfg <= '0;
         o_tx_cfg <= '0;
      end else begin
         if (wr_fire) begin
            bvalid <= 1'b1;
         end else if (i_axil_req.bready) begin
            bvalid <= 1'b0;
         end
         if (rd_fire) begin
            rvalid <= 1'b1;
         end else if (i_axil_req.rready) begin
            rvalid <= 1'b0;
         end

         if (wr_fire && wr_chan_ok) begin
            case (wr_reg)   // strobes ignored, full word writes
               SR_TX_FE_BASE + SR_OFF_I:  o_tx_cfg[wr_chan].offset_i <= i_axil_req.wdata[SAMP_W-1:0];
               SR_TX_FE_BASE + SR_OFF_Q:  o_tx_cfg[wr_chan].offset_q <= i_axil_req.wdata[SAMP_W-1:0];
               SR_TX_FE_BASE + SR_IQ_MAP: o_tx_cfg[wr_chan].iq_swap  <= i_axil_req.wdata[0];
               SR_RX_FE_BASE + SR_OFF_I:  o_rx_cfg[wr_chan].offset_i <= i_axil_req.wdata[SAMP_W-1:0];
               SR_RX_FE_BASE + SR_OFF_Q:  o_rx_cfg[wr_chan].offset_q <= i_axil_req.wdata[SAMP_W-1:0];
               SR_RX_FE_BASE + SR_IQ_MAP: o_rx_cfg[wr_chan].iq_swap  <= i_axil_req.wdata[0];
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read mux, unmapped words read as zero
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_word = '0;
      if (rd_idx == IDX_W'(SR_STATUS)) begin
         rd_word[2*NUM_CHAN-1:0] = i_status;
      end else if (rd_chan_ok) begin
         case (rd_reg)
            SR_TX_FE_BASE + SR_OFF_I:  rd_word[SAMP_W-1:0] = o_tx_cfg[rd_chan].offset_i;
            SR_TX_FE_BASE + SR_OFF_Q:  rd_word[SAMP_W-1:0] = o_tx_cfg[rd_chan].offset_q;
            SR_TX_FE_BASE + SR_IQ_MAP: rd_word[0]          = o_tx_cfg[rd_chan].iq_swap;
            SR_RX_FE_BASE + SR_OFF_I:  rd_word[SAMP_W-1:0] = o_rx_cfg[rd_chan].offset_i;
            SR_RX_FE_BASE + SR_OFF_Q:  rd_word[SAMP_W-1:0] = o_rx_cfg[rd_chan].offset_q;
            SR_RX_FE_BASE + SR_IQ_MAP: rd_word[0]          = o_rx_cfg[rd_chan].iq_swap;
            default: ;
         endcase
      end
   end

   always_ff @(posedge radio_clk) begin
      if (rd_fire) begin
         rdata <= rd_word;   // held while rvalid waits on rready
      end
   end

   always_comb begin
      o_axil_rsp         = '0;
      o_axil_rsp.awready = wr_fire;
      o_axil_rsp.wready  = wr_fire;
      o_axil_rsp.bvalid  = bvalid;
      o_axil_rsp.bresp   = AXI_RESP_OKAY;
      o_axil_rsp.arready = ~rvalid;
      o_axil_rsp.rvalid  = rvalid;
      o_axil_rsp.rdata   = rdata;
      o_axil_rsp.rresp   = AXI_RESP_OKAY;
   end

endmodule

`default_nettype wire

// ==== source/rx_fe_corr.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fe_corr
   import radio_fe_pkg::*;
(
   input  wire             radio_clk,
   input  wire             i_arst_n,
   input  wire fe_rx_cfg_t i_cfg,
   input  wire iq_t        i_adc,
   output iq_t             o_rx,
   output logic            o_rx_valid,
   output logic            o_sat
);

   logic [SAMP_W:0]   s1_sum_i;   // one guard bit
   logic [SAMP_W:0]   s1_sum_q;
   logic              s1_swap;
   logic [1:0]        vld_sr;
   logic [SAMP_W-1:0] clip_i;
   logic [SAMP_W-1:0] clip_q;

   ////////////////////////////////////////////////////////////////////////////
   // stage 1, dc offset
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      s1_sum_i <= {i_adc.i[SAMP_W-1], i_adc.i} + {i_cfg.offset_i[SAMP_W-1], i_cfg.offset_i};
      s1_sum_q <= {i_adc.q[SAMP_W-1], i_adc.q} + {i_cfg.offset_q[SAMP_W-1], i_cfg.offset_q};
      s1_swap  <= i_cfg.iq_swap;   // follows its sample
   end

   ////////////////////////////////////////////////////////////////////////////
   // stage 2, clip and i/q map
   ////////////////////////////////////////////////////////////////////////////
   assign clip_i = clip_sample(s1_sum_i);
   assign clip_q = clip_sample(s1_sum_q);

   always_ff @(posedge radio_clk) begin
      o_rx.i <= s1_swap ? clip_q : clip_i;
      o_rx.q <= s1_swap ? clip_i : clip_q;
   end

   // adc runs every cycle, so valid just fills after reset
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         vld_sr <= '0;
         o_sat  <= 1'b0;
      end else begin
         vld_sr <= {vld_sr[0], 1'b1};
         o_sat  <= vld_sr[0] & (sample_clipped(s1_sum_i) | sample_clipped(s1_sum_q));
      end
   end

   assign o_rx_valid = vld_sr[1];

endmodule

`default_nettype wire

// ==== source/tx_fe_corr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_fe_corr
   import radio_fe_pkg::*;
(
   input  wire             radio_clk,
   input  wire             i_arst_n,
   input  wire fe_tx_cfg_t i_cfg,
   input  wire iq_t        i_tx,
   input  wire             i_tx_valid,
   output iq_t             o_dac,
   output logic            o_dac_valid,
   output logic            o_sat
);

   logic [SAMP_W:0]   s1_sum_i;
   logic [SAMP_W:0]   s1_sum_q;
   logic              s1_swap;
   logic              s1_vld;
   logic [SAMP_W-1:0] clip_i;
   logic [SAMP_W-1:0] clip_q;

   assign clip_i = clip_sample(s1_sum_i);
   assign clip_q = clip_sample(s1_sum_q);

   // payload moves only with a valid sample
   always_ff @(posedge radio_clk) begin
      if (i_tx_valid) begin
         s1_sum_i <= {i_tx.i[SAMP_W-1], i_tx.i} + {i_cfg.offset_i[SAMP_W-1], i_cfg.offset_i};
         s1_sum_q <= {i_tx.q[SAMP_W-1], i_tx.q} + {i_cfg.offset_q[SAMP_W-1], i_cfg.offset_q};
         s1_swap  <= i_cfg.iq_swap;
      end
      if (s1_vld) begin
         o_dac.i <= s1_swap ? clip_q : clip_i;   // swap after clip
         o_dac.q <= s1_swap ? clip_i : clip_q;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // valid pipe, two samples may be in flight
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         s1_vld      <= 1'b0;
         o_dac_valid <= 1'b0;
         o_sat       <= 1'b0;
      end else begin
         s1_vld      <= i_tx_valid;
         o_dac_valid <= s1_vld;
         o_sat       <= s1_vld & (sample_clipped(s1_sum_i) | sample_clipped(s1_sum_q));
      end
   end

endmodule

`default_nettype wire

// ==== source/fe_sat_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_sat_monitor #(
   parameter int NUM_CHAN = 2
) (
   input  wire                    radio_clk,
   input  wire                    i_arst_n,
   input  wire [NUM_CHAN-1:0]     i_rx_sat,
   input  wire [NUM_CHAN-1:0]     i_tx_sat,
   input  wire [2*NUM_CHAN-1:0]   i_clr,
   output logic [2*NUM_CHAN-1:0]  o_status
);

   logic [2*NUM_CHAN-1:0] sat_evt;

   // interleave, rx on even bits and tx on odd bits
   always_comb begin
      for (int c = 0; c < NUM_CHAN; c++) begin
         sat_evt[2*c]   = i_rx_sat[c];
         sat_evt[2*c+1] = i_tx_sat[c];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sticky flags, write one to clear
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_status <= '0;
      end else begin
         // a new event wins over a clear in the same cycle
         o_status <= (o_status & ~i_clr) | sat_evt;
      end
   end

endmodule

`default_nettype wire

// ==== source/radio_fe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module radio_fe_top
   import radio_fe_pkg::*;
#(
   parameter int NUM_CHAN = 2
) (
   input  wire                      radio_clk,
   input  wire                      i_arst_n,
   input  wire axil_req_t           i_axil_req,
   output wire axil_rsp_t           o_axil_rsp,
   input  wire iq_t                 i_adc,
   input  wire iq_t [NUM_CHAN-1:0]  i_tx,
   input  wire [NUM_CHAN-1:0]       i_tx_valid,
   output wire iq_t [NUM_CHAN-1:0]  o_rx,
   output wire                      o_rx_valid,
   output wire iq_t [NUM_CHAN-1:0]  o_dac,
   output wire [NUM_CHAN-1:0]       o_dac_valid
);

   wire fe_rx_cfg_t [NUM_CHAN-1:0] rx_cfg;
   wire fe_tx_cfg_t [NUM_CHAN-1:0] tx_cfg;
   wire [NUM_CHAN-1:0]             rx_sat;
   wire [NUM_CHAN-1:0]             tx_sat;
   wire [NUM_CHAN-1:0]             rx_valid;
   wire [2*NUM_CHAN-1:0]           status;
   wire [2*NUM_CHAN-1:0]           status_clr;

   fe_axil_regs #(.NUM_CHAN(NUM_CHAN)) u_regs (
      .radio_clk    (radio_clk),
      .i_arst_n     (i_arst_n),
      .i_axil_req   (i_axil_req),
      .o_axil_rsp   (o_axil_rsp),
      .o_rx_cfg     (rx_cfg),
      .o_tx_cfg     (tx_cfg),
      .i_status     (status),
      .o_status_clr (status_clr)
   );

   ////////////////////////////////////////////////////////////////////////////
   // per channel correction, one shared adc stream
   ////////////////////////////////////////////////////////////////////////////
   for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
      rx_fe_corr u_rx (
         .radio_clk(radio_clk), .i_arst_n(i_arst_n), .i_cfg(rx_cfg[c]),
         .i_adc(i_adc), .o_rx(o_rx[c]), .o_rx_valid(rx_valid[c]), .o_sat(rx_sat[c])
      );
      tx_fe_corr u_tx (
         .radio_clk(radio_clk), .i_arst_n(i_arst_n), .i_cfg(tx_cfg[c]),
         .i_tx(i_tx[c]), .i_tx_valid(i_tx_valid[c]),
         .o_dac(o_dac[c]), .o_dac_valid(o_dac_valid[c]), .o_sat(tx_sat[c])
      );
   end

   assign o_rx_valid = &rx_valid;   // identical on every channel

   fe_sat_monitor #(.NUM_CHAN(NUM_CHAN)) u_sat_mon (
      .radio_clk (radio_clk),
      .i_arst_n  (i_arst_n),
      .i_rx_sat  (rx_sat),
      .i_tx_sat  (tx_sat),
      .i_clr     (status_clr),
      .o_status  (status)
   );

endmodule

`default_nettype wire

// ==== tb/tb_radio_fe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_radio_fe
   import radio_fe_pkg::*;
;

   localparam int NUM_CHAN  = 2;
   localparam int LEN_RESET = 16;
   localparam int LEN_REGS  = 100;
   localparam int LEN_RX    = 120;
   localparam int LEN_TX    = 120;
   localparam int LEN_SAT   = 150;
   localparam int LEN_HS    = 150;
   localparam int MAX_CYC   =
      2 * (LEN_RESET + LEN_REGS + LEN_RX + LEN_TX + LEN_SAT + LEN_HS) + 200;

   typedef struct packed {
      iq_t [NUM_CHAN-1:0]    rx;
      logic [NUM_CHAN-1:0]   dv;
      iq_t [NUM_CHAN-1:0]    dac;
      logic [2*NUM_CHAN-1:0] sat;   // rx on even bits, tx on odd
   } exp_t;

   logic                  radio_clk;
   logic                  i_arst_n;
   axil_req_t             axil_req;
   axil_rsp_t             axil_rsp;
   iq_t                   adc;
   iq_t [NUM_CHAN-1:0]    tx;
   logic [NUM_CHAN-1:0]   tx_valid;
   iq_t [NUM_CHAN-1:0]    rx_out;
   logic                  rx_valid;
   iq_t [NUM_CHAN-1:0]    dac;
   logic [NUM_CHAN-1:0]   dac_valid;

   logic [15:0]           ctl_lfsr = 16'd34;
   logic [15:0]           data_lfsr = 16'd34;
   logic [15:0]           m_cfg [NUM_CHAN][6];   // 0..2 tx regs, 3..5 rx regs
   logic [2*NUM_CHAN-1:0] model_status = '0;
   exp_t                  exp_q [$];
   logic                  sat_mode = 1'b0;
   logic                  tx_on = 1'b0;
   int                    err_cnt = 0;
   int                    n_checks = 0;
   int                    n_tests = 0;
   int                    n_failed = 0;
   int                    cyc_cnt = 0;

   radio_fe_top #(.NUM_CHAN(NUM_CHAN)) dut (
      .radio_clk   (radio_clk),
      .i_arst_n    (i_arst_n),
      .i_axil_req  (axil_req),
      .o_axil_rsp  (axil_rsp),
      .i_adc       (adc),
      .i_tx        (tx),
      .i_tx_valid  (tx_valid),
      .o_rx        (rx_out),
      .o_rx_valid  (rx_valid),
      .o_dac       (dac),
      .o_dac_valid (dac_valid)
   );

   initial begin
      radio_clk = 1'b0;
      forever begin
         #50 radio_clk = ~radio_clk;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // random numbers, 16-bit fibonacci lfsr
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_ctl(input int n);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         ctl_lfsr = lfsr_step(ctl_lfsr);
         v = {v[30:0], ctl_lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] rand_data(input int n);   // sample stream
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < n; b++) begin
         data_lfsr = lfsr_step(data_lfsr);
         v = {v[30:0], data_lfsr[0]};
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic int reg_idx(input int c, input int k);
      return (c << CHAN_SHIFT) + ((k < 3) ? SR_TX_FE_BASE + k : SR_RX_FE_BASE + k - 3);
   endfunction

   function automatic logic [15:0] clamp16(input int v);
      if (v > 32767) begin
         return 16'h7fff;
      end else if (v < -32768) begin
         return 16'h8000;
      end
      return 16'(v);
   endfunction

   // {clipped, corrected sample}
   function automatic logic [32:0] correct_iq(input iq_t x, input logic [15:0] oi,
                                              input logic [15:0] oq, input logic sw);
      int  si;
      int  sq;
      iq_t y;
      si = int'(x.i) + int'($signed(oi));
      sq = int'(x.q) + int'($signed(oq));
      y.i = sw ? clamp16(sq) : clamp16(si);
      y.q = sw ? clamp16(si) : clamp16(sq);
      return {(si != int'($signed(clamp16(si)))) || (sq != int'($signed(clamp16(sq)))), y};
   endfunction

   function automatic void model_write(input int idx, input logic [31:0] data);
      int chan;
      int r;
      int k;
      chan = idx >> CHAN_SHIFT;
      r    = idx % (1 << CHAN_SHIFT);
      k    = -1;
      if (r >= SR_TX_FE_BASE && r <= SR_TX_FE_BASE + SR_IQ_MAP) k = r - SR_TX_FE_BASE;
      if (r >= SR_RX_FE_BASE && r <= SR_RX_FE_BASE + SR_IQ_MAP) k = r - SR_RX_FE_BASE + 3;
      if (idx == SR_STATUS) begin
         model_status &= ~data[2*NUM_CHAN-1:0];   // write one to clear
      end else if (chan < NUM_CHAN && k >= 0) begin
         m_cfg[chan][k] = (k % 3 == SR_IQ_MAP) ? {15'b0, data[0]} : data[15:0];
      end
   endfunction

   function automatic logic [31:0] model_read(input int idx);
      int chan;
      int r;
      chan = idx >> CHAN_SHIFT;
      r    = idx % (1 << CHAN_SHIFT);
      if (idx == SR_STATUS) return 32'(model_status);
      if (chan >= NUM_CHAN) return '0;
      if (r >= SR_TX_FE_BASE && r <= SR_TX_FE_BASE + SR_IQ_MAP)
         return 32'(m_cfg[chan][r - SR_TX_FE_BASE]);
      if (r >= SR_RX_FE_BASE && r <= SR_RX_FE_BASE + SR_IQ_MAP)
         return 32'(m_cfg[chan][r - SR_RX_FE_BASE + 3]);
      return '0;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sample stimulus and checking
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge radio_clk) begin
      logic [31:0] r;
      #10;
      if (sat_mode) begin   // large positive values, clip with offset 7fff
         r = rand_data(28);
         adc.i = {2'b01, r[13:0]};
         adc.q = {2'b01, r[27:14]};
         for (int c = 0; c < NUM_CHAN; c++) begin
            r = rand_data(28);
            tx[c].i = {2'b01, r[13:0]};
            tx[c].q = {2'b01, r[27:14]};
         end
         tx_valid = '1;
      end else begin
         adc = rand_data(32);
         for (int c = 0; c < NUM_CHAN; c++) begin
            tx[c] = rand_data(32);
         end
         tx_valid = tx_on ? NUM_CHAN'(rand_data(NUM_CHAN)) : '0;
      end
   end

   always @(posedge radio_clk) begin
      exp_t        e;
      exp_t        due;
      logic [32:0] r;
      if (i_arst_n) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            r = correct_iq(adc, m_cfg[c][3], m_cfg[c][4], m_cfg[c][5][0]);
            e.rx[c]      = r[31:0];
            e.sat[2*c]   = r[32];
            r = correct_iq(tx[c], m_cfg[c][0], m_cfg[c][1], m_cfg[c][2][0]);
            e.dac[c]     = r[31:0];
            e.dv[c]      = tx_valid[c];
            e.sat[2*c+1] = r[32] & tx_valid[c];
         end
         exp_q.push_back(e);
         #5;
         if (exp_q.size() > 1) begin   // sample taken at the previous edge is out now
            due = exp_q.pop_front();
            check_val("o_rx_valid", rx_valid, 1);
            for (int c = 0; c < NUM_CHAN; c++) begin
               check_val($sformatf("o_rx[%0d]", c), rx_out[c], due.rx[c]);
               check_val($sformatf("o_dac_valid[%0d]", c), dac_valid[c], due.dv[c]);
               if (due.dv[c]) begin
                  check_val($sformatf("o_dac[%0d]", c), dac[c], due.dac[c]);
               end
            end
            model_status |= due.sat;
         end
      end
   end

   always @(posedge radio_clk) begin
      cyc_cnt++;
      if (cyc_cnt >= MAX_CYC) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYC);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // axi4-lite master
   ////////////////////////////////////////////////////////////////////////////
   task automatic next_cycle();
      @(posedge radio_clk);
      #10;
   endtask

   task automatic axil_write(input int idx, input logic [31:0] data, input int hold);
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = AXIL_ADDR_W'(idx * 4);
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.bready  = 1'b0;
      #1;
      while (!(axil_rsp.awready && axil_rsp.wready)) begin
         next_cycle();
         #1;
      end
      next_cycle();
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      model_write(idx, data);
      repeat (hold) begin
         next_cycle();
         #1;
         check_val("arready", axil_rsp.arready, 1);   // read side stays free
      end
      #1;
      check_val("bvalid", axil_rsp.bvalid, 1);
      check_val("bresp", axil_rsp.bresp, AXI_RESP_OKAY);
      axil_req.bready = 1'b1;
      next_cycle();
      axil_req.bready = 1'b0;
      check_val("bvalid", axil_rsp.bvalid, 0);
   endtask

   task automatic axil_read(input int idx, input int hold, output logic [31:0] data);
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = AXIL_ADDR_W'(idx * 4);
      axil_req.rready  = 1'b0;
      #1;
      while (!axil_rsp.arready) begin
         next_cycle();
         #1;
      end
      next_cycle();
      axil_req.arvalid = 1'b0;
      repeat (hold) next_cycle();
      #1;
      check_val("rvalid", axil_rsp.rvalid, 1);
      check_val("rresp", axil_rsp.rresp, AXI_RESP_OKAY);
      data = axil_rsp.rdata;
      axil_req.rready = 1'b1;
      next_cycle();
      axil_req.rready = 1'b0;
      check_val("rvalid", axil_rsp.rvalid, 0);
   endtask

   task automatic read_expect(input int idx, input int hold);
      logic [31:0] d;
      axil_read(idx, hold, d);
      check_val($sformatf("rdata[%0d]", idx), d, model_read(idx));
   endtask

   task automatic end_test(input string name, input int e0);
      n_tests++;
      if (err_cnt == e0) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         n_failed++;
         $display("test %0d %s: %0d errors", n_tests, name, err_cnt - e0);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic test_regs();
      int e0;
      e0 = err_cnt;
      for (int c = 0; c < NUM_CHAN; c++) begin
         for (int k = 0; k < 6; k++) axil_write(reg_idx(c, k), rand_ctl(32), 0);
      end
      for (int c = 0; c < NUM_CHAN; c++) begin
         for (int k = 0; k < 6; k++) read_expect(reg_idx(c, k), 0);
      end
      read_expect(100, 0);                                  // hole in the map
      read_expect((NUM_CHAN << CHAN_SHIFT) + SR_RX_FE_BASE, 0);   // no such channel
      end_test("register readback", e0);
   endtask

   task automatic test_corr(input string name, input int first_k);
      int e0;
      e0 = err_cnt;
      for (int round = 0; round < 2; round++) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            axil_write(reg_idx(c, first_k), rand_ctl(16), 0);
            axil_write(reg_idx(c, first_k + 1), rand_ctl(16), 0);
            axil_write(reg_idx(c, first_k + 2), rand_ctl(1), 0);
         end
         repeat (40) next_cycle();
      end
      end_test(name, e0);
   endtask

   task automatic test_sat();
      int          e0;
      logic [3:0]  mask;
      e0 = err_cnt;
      for (int c = 0; c < NUM_CHAN; c++) begin
         for (int k = 0; k < 6; k++) axil_write(reg_idx(c, k), 0, 0);
      end
      repeat (4) next_cycle();   // drain samples with the old offsets
      axil_write(SR_STATUS, 32'hf, 0);
      read_expect(SR_STATUS, 0);
      mask = rand_ctl(2 * NUM_CHAN) | 4'b0011;   // channel 0 clips on both chains
      sat_mode = 1'b1;
      for (int c = 0; c < NUM_CHAN; c++) begin
         if (mask[2*c])   axil_write(reg_idx(c, 3), 32'h7fff, 0);
         if (mask[2*c+1]) axil_write(reg_idx(c, 0), 32'h7fff, 0);
      end
      repeat (20) next_cycle();
      for (int c = 0; c < NUM_CHAN; c++) begin
         axil_write(reg_idx(c, 3), 0, 0);
         axil_write(reg_idx(c, 0), 0, 0);
      end
      sat_mode = 1'b0;
      repeat (4) next_cycle();
      read_expect(SR_STATUS, 0);
      // partial clear, bit 0 always cleared and bit 1 always kept
      axil_write(SR_STATUS, (rand_ctl(2 * NUM_CHAN) & ~32'h2) | 32'h1, 0);
      read_expect(SR_STATUS, 0);
      repeat (16) next_cycle();   // unclipped traffic
      read_expect(SR_STATUS, 0);
      end_test("saturation status", e0);
   endtask

   task automatic test_handshake();
      int e0;
      int idx;
      e0 = err_cnt;
      for (int n = 0; n < 6; n++) begin
         idx = reg_idx(int'(rand_ctl(1)), int'(rand_ctl(3) % 6));
         axil_write(idx, rand_ctl(32), int'(rand_ctl(3)));
         read_expect(idx, int'(rand_ctl(3)));
      end
      end_test("axi4-lite handshake", e0);
   endtask

   initial begin
      i_arst_n = 1'b0;
      axil_req = '0;
      adc      = '0;
      tx       = '0;
      tx_valid = '0;
      for (int c = 0; c < NUM_CHAN; c++) begin
         for (int k = 0; k < 6; k++) m_cfg[c][k] = '0;
      end
      repeat (LEN_RESET) @(posedge radio_clk);
      #10;
      i_arst_n = 1'b1;

      test_regs();
      test_corr("receive correction", 3);
      tx_on = 1'b1;
      test_corr("transmit correction", 0);
      test_sat();
      test_handshake();
      repeat (4) next_cycle();

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               n_tests, n_failed, n_checks, err_cnt);
      if (n_failed == 0 && err_cnt == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
source/radio_fe_pkg.sv
source/fe_axil_regs.sv
source/rx_fe_corr.sv
source/tx_fe_corr.sv
source/fe_sat_monitor.sv
source/radio_fe_top.sv
tb/tb_radio_fe.sv

// ==== Bender.yml ====
package:
  name: radio_fe

sources:
  - files:
      - source/radio_fe_pkg.sv
      - source/fe_axil_regs.sv
      - source/rx_fe_corr.sv
      - source/tx_fe_corr.sv
      - source/fe_sat_monitor.sv
      - source/radio_fe_top.sv
  - target: test
    files:
      - tb/tb_radio_fe.sv
